// File: csi2_pkg.sv
// Single-lane CSI-2 header layout, the first header byte on the wire lands in bits 7:0
package csi2_pkg;

    localparam logic [5:0] DT_FRAME_START = 6'h00;
    localparam logic [5:0] DT_FRAME_END   = 6'h01;
    localparam logic [5:0] DT_RAW10       = 6'h2B;

    localparam int HEADER_BYTES = 4;

    // Parser states
    localparam logic [1:0] ST_HEADER  = 2'd0;
    localparam logic [1:0] ST_PAYLOAD = 2'd1;
    localparam logic [1:0] ST_SKIP    = 2'd2;

    typedef union packed {
        struct packed {
            logic [7:0]  ecc;
            logic [15:0] word_count;   // Payload bytes that follow
            logic [7:0]  data_id;      // Virtual channel 7:6, data type 5:0
        } long_pkt;
        struct packed {
            logic [7:0]  ecc;
            logic [15:0] frame_number;
            logic [7:0]  data_id;
        } short_pkt;
    } csi2_header_t;

endpackage

// File: image_pkg.sv
// Fixed crop window and metering scale, CROP_PIXELS must match the window and be a power of two
package image_pkg;

    localparam int PIXEL_BITS = 10;

    localparam int COORD_BITS = 12;    // Up to 4095 columns and lines

    // Window limits, inclusive
    localparam logic [COORD_BITS-1:0] CROP_X_START = COORD_BITS'(2);
    localparam logic [COORD_BITS-1:0] CROP_X_END   = COORD_BITS'(17);
    localparam logic [COORD_BITS-1:0] CROP_Y_START = COORD_BITS'(1);
    localparam logic [COORD_BITS-1:0] CROP_Y_END   = COORD_BITS'(2);

    localparam int CROP_PIXELS = 32;   // 16 columns by 2 lines

    localparam int METER_BITS = 8;

    // Sum of a full window never overflows this width
    localparam int METER_ACC_BITS = PIXEL_BITS + $clog2(CROP_PIXELS);

    // Divide by the window size and drop the two low pixel bits
    localparam int METER_SHIFT = METER_ACC_BITS - METER_BITS;

endpackage

// File: csi2_packet_parser.sv
// Single lane only, ECC is stored but never checked, short packets other than FS and FE are dropped
`timescale 1ns/1ps

module csi2_packet_parser (
    input  logic       mipi_byte_clock,
    input  logic       mipi_byte_reset_n,

    input  logic [7:0] byte_i,
    input  logic       byte_valid_i,

    output logic [7:0] payload_o,
    output logic       payload_valid_o,
    output logic       line_end_o,
    output logic       frame_start_o,
    output logic       frame_end_o,
    output logic       frame_active_o
);

    import csi2_pkg::*;

    logic [1:0]   state;
    logic [1:0]   byte_count;
    logic [15:0]  remaining;
    logic         last_byte;
    csi2_header_t header;
    csi2_header_t header_next;
    logic [5:0]   data_type;
    logic [15:0]  word_count;
    logic         is_short;
    logic         header_done;

    // Header as it stands once the current byte is in
    always_comb begin
        header_next = header;
        header_next[8*byte_count +: 8] = byte_i;
    end

    assign data_type   = header_next.short_pkt.data_id[5:0];
    assign word_count  = header_next.long_pkt.word_count;
    assign is_short    = (data_type[5:4] == 2'b00);   // Types 0x00 to 0x0F
    assign header_done = byte_valid_i && (state == ST_HEADER)
                         && (byte_count == 2'(HEADER_BYTES - 1));

    always_ff @(posedge mipi_byte_clock) begin
        if (byte_valid_i && state == ST_HEADER) header <= header_next;
        if (byte_valid_i && state == ST_PAYLOAD) payload_o <= byte_i;
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            state           <= ST_HEADER;
            byte_count      <= 2'd0;
            remaining       <= 16'd0;
            last_byte       <= 1'b0;
            payload_valid_o <= 1'b0;
            line_end_o      <= 1'b0;
            frame_start_o   <= 1'b0;
            frame_end_o     <= 1'b0;
            frame_active_o  <= 1'b0;
        end else begin
            payload_valid_o <= 1'b0;
            frame_start_o   <= 1'b0;
            frame_end_o     <= 1'b0;
            line_end_o      <= last_byte;     // One cycle behind the last payload byte
            last_byte       <= 1'b0;

            if (byte_valid_i) begin
                case (state)
                    ST_HEADER: begin
                        byte_count <= byte_count + 2'd1;   // Wraps after the ECC byte
                    end
                    ST_PAYLOAD: begin
                        payload_valid_o <= 1'b1;
                        remaining       <= remaining - 16'd1;
                        if (remaining == 16'd1) begin
                            last_byte <= 1'b1;
                            state     <= ST_HEADER;
                        end
                    end
                    default: begin
                        remaining <= remaining - 16'd1;
                        if (remaining == 16'd1) state <= ST_HEADER;
                    end
                endcase
            end

            if (header_done) begin
                if (is_short) begin
                    if (data_type == DT_FRAME_START) begin
                        frame_active_o <= 1'b1;
                        frame_start_o  <= 1'b1;
                    end else if (data_type == DT_FRAME_END && frame_active_o) begin
                        frame_active_o <= 1'b0;
                        frame_end_o    <= 1'b1;
                    end
                end else if (word_count != 16'd0) begin
                    remaining <= word_count;
                    // Only RAW10 inside a frame reaches the unpacker
                    state     <= (data_type == DT_RAW10 && frame_active_o) ? ST_PAYLOAD : ST_SKIP;
                end
            end
        end
    end

endmodule

// File: raw10_unpacker.sv
// Line payload must be a whole number of 5-byte groups, a trailing partial group is dropped
`timescale 1ns/1ps

module raw10_unpacker (
    input  logic                             mipi_byte_clock,
    input  logic                             mipi_byte_reset_n,

    input  logic [7:0]                       payload_i,
    input  logic                             payload_valid_i,
    input  logic                             line_end_i,
    input  logic                             frame_start_i,
    input  logic                             frame_end_i,

    output logic [image_pkg::PIXEL_BITS-1:0] pixel_o,
    output logic                             pixel_valid_o,
    output logic                             line_end_o,
    output logic                             frame_start_o,
    output logic                             frame_end_o
);

    import image_pkg::*;

    logic [2:0]            byte_index;
    logic [7:0]            msb_bytes [0:3];
    logic [PIXEL_BITS-1:0] queue [0:3];
    logic [2:0]            queue_count;
    logic                  group_done;
    logic                  queue_empty;
    logic                  line_pending;
    logic                  frame_pending;

    assign group_done  = payload_valid_i && (byte_index == 3'd4);
    assign queue_empty = (queue_count == 3'd0);

    always_ff @(posedge mipi_byte_clock) begin
        if (payload_valid_i && byte_index != 3'd4) msb_bytes[byte_index[1:0]] <= payload_i;

        if (group_done) begin
            // Fifth byte holds the low bit pairs, pixel 0 in bits 1:0
            for (int i = 0; i < 4; i++) begin
                queue[i] <= {msb_bytes[i], payload_i[2*i +: 2]};
            end
        end else if (!queue_empty) begin
            for (int i = 0; i < 3; i++) begin
                queue[i] <= queue[i + 1];
            end
        end

        if (!queue_empty) pixel_o <= queue[0];
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            byte_index    <= 3'd0;
            queue_count   <= 3'd0;
            line_pending  <= 1'b0;
            frame_pending <= 1'b0;
            pixel_valid_o <= 1'b0;
            line_end_o    <= 1'b0;
            frame_start_o <= 1'b0;
            frame_end_o   <= 1'b0;
        end else begin
            pixel_valid_o <= !queue_empty;
            frame_start_o <= frame_start_i;
            line_end_o    <= line_pending && queue_empty;   // Held until drained
            frame_end_o   <= frame_pending && queue_empty;

            line_pending  <= line_end_i || (line_pending && !queue_empty);
            frame_pending <= frame_end_i || (frame_pending && !queue_empty);

            if (group_done) queue_count <= 3'd4;
            else if (!queue_empty) queue_count <= queue_count - 3'd1;

            if (line_end_i || frame_start_i) byte_index <= 3'd0;   // Resync on line boundary
            else if (payload_valid_i) byte_index <= group_done ? 3'd0 : byte_index + 3'd1;
        end
    end

endmodule

// File: crop.sv
// Window limits are fixed in image_pkg, every line must close with a line-end pulse
`timescale 1ns/1ps

module crop (
    input  logic                             mipi_byte_clock,
    input  logic                             mipi_byte_reset_n,

    input  logic [image_pkg::PIXEL_BITS-1:0] pixel_i,
    input  logic                             pixel_valid_i,
    input  logic                             line_end_i,
    input  logic                             frame_start_i,
    input  logic                             frame_end_i,

    output logic [image_pkg::PIXEL_BITS-1:0] pixel_o,
    output logic                             pixel_valid_o,
    output logic                             frame_start_o,
    output logic                             frame_end_o
);

    import image_pkg::*;

    logic [COORD_BITS-1:0] column;
    logic [COORD_BITS-1:0] line;
    logic                  in_window;

    assign in_window = (column >= CROP_X_START) && (column <= CROP_X_END)
                       && (line >= CROP_Y_START) && (line <= CROP_Y_END);

    always_ff @(posedge mipi_byte_clock) begin
        if (pixel_valid_i) pixel_o <= pixel_i;
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            column        <= '0;
            line          <= '0;
            pixel_valid_o <= 1'b0;
            frame_start_o <= 1'b0;
            frame_end_o   <= 1'b0;
        end else begin
            pixel_valid_o <= pixel_valid_i && in_window;
            frame_start_o <= frame_start_i;
            frame_end_o   <= frame_end_i;

            if (frame_start_i) begin
                column <= '0;
                line   <= '0;
            end else if (line_end_i) begin
                column <= '0;
                line   <= line + 1'b1;
            end else if (pixel_valid_i) begin
                column <= column + 1'b1;
            end
        end
    end

endmodule

// File: metering.sv
// Divides by the fixed window size, so a frame with missing pixels reads darker
`timescale 1ns/1ps

module metering (
    input  logic                             mipi_byte_clock,
    input  logic                             mipi_byte_reset_n,

    input  logic [image_pkg::PIXEL_BITS-1:0] pixel_i,
    input  logic                             pixel_valid_i,
    input  logic                             frame_start_i,
    input  logic                             frame_end_i,

    output logic [image_pkg::METER_BITS-1:0] brightness_o,
    output logic                             brightness_valid_o
);

    import image_pkg::*;

    logic [METER_ACC_BITS-1:0] accumulator;

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            accumulator        <= '0;
            brightness_o       <= '0;
            brightness_valid_o <= 1'b0;
        end else begin
            brightness_valid_o <= frame_end_i;

            if (frame_start_i) begin
                accumulator <= '0;
            end else if (pixel_valid_i) begin
                accumulator <= accumulator + METER_ACC_BITS'(pixel_i);
            end

            // Shift right by METER_SHIFT, holds until the next frame end
            if (frame_end_i) brightness_o <= accumulator[METER_SHIFT +: METER_BITS];
        end
    end

endmodule

// File: camera_rx.sv
// Byte-clock receive path behind a single-lane CSI-2 hard block, no back-pressure anywhere
`timescale 1ns/1ps

module camera_rx (
    input  logic                             mipi_byte_clock,
    input  logic                             mipi_byte_reset_n,

    input  logic [7:0]                       byte_i,
    input  logic                             byte_valid_i,

    output logic [image_pkg::PIXEL_BITS-1:0] pixel_o,
    output logic                             pixel_valid_o,
    output logic                             frame_active_o,

    output logic [image_pkg::METER_BITS-1:0] brightness_o,
    output logic                             brightness_valid_o
);

    import image_pkg::*;

    logic [7:0]            payload;
    logic                  payload_valid;
    logic                  parser_line_end;
    logic                  parser_frame_start;
    logic                  parser_frame_end;

    logic [PIXEL_BITS-1:0] raw_pixel;
    logic                  raw_pixel_valid;
    logic                  raw_line_end;
    logic                  raw_frame_start;
    logic                  raw_frame_end;

    logic                  crop_frame_start;
    logic                  crop_frame_end;

    csi2_packet_parser parser0 (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .byte_i            (byte_i),
        .byte_valid_i      (byte_valid_i),
        .payload_o         (payload),
        .payload_valid_o   (payload_valid),
        .line_end_o        (parser_line_end),
        .frame_start_o     (parser_frame_start),
        .frame_end_o       (parser_frame_end),
        .frame_active_o    (frame_active_o)
    );

    raw10_unpacker unpacker0 (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .payload_i         (payload),
        .payload_valid_i   (payload_valid),
        .line_end_i        (parser_line_end),
        .frame_start_i     (parser_frame_start),
        .frame_end_i       (parser_frame_end),
        .pixel_o           (raw_pixel),
        .pixel_valid_o     (raw_pixel_valid),
        .line_end_o        (raw_line_end),
        .frame_start_o     (raw_frame_start),
        .frame_end_o       (raw_frame_end)
    );

    crop crop0 (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .pixel_i           (raw_pixel),
        .pixel_valid_i     (raw_pixel_valid),
        .line_end_i        (raw_line_end),
        .frame_start_i     (raw_frame_start),
        .frame_end_i       (raw_frame_end),
        .pixel_o           (pixel_o),
        .pixel_valid_o     (pixel_valid_o),
        .frame_start_o     (crop_frame_start),
        .frame_end_o       (crop_frame_end)
    );

    metering metering0 (
        .mipi_byte_clock    (mipi_byte_clock),
        .mipi_byte_reset_n  (mipi_byte_reset_n),
        .pixel_i            (pixel_o),
        .pixel_valid_i      (pixel_valid_o),
        .frame_start_i      (crop_frame_start),
        .frame_end_i        (crop_frame_end),
        .brightness_o       (brightness_o),
        .brightness_valid_o (brightness_valid_o)
    );

endmodule

// File: tb_clock.sv
// Free-running 4 ns clock, reset held low for the first three rising edges
`timescale 1ns/1ps

module tb_clock (
    output logic mipi_byte_clock_o,
    output logic mipi_byte_reset_n_o
);

    initial begin
        mipi_byte_clock_o = 1'b0;
        forever #2 mipi_byte_clock_o = ~mipi_byte_clock_o;
    end

    initial begin
        mipi_byte_reset_n_o = 1'b0;
        repeat (3) @(posedge mipi_byte_clock_o);
        mipi_byte_reset_n_o <= 1'b1;   // Released on an edge, like the receiver block
    end

endmodule

// File: camera_rx_tb.sv
// Reads camera_trace.txt from the working directory, expected values assume the image_pkg window
`timescale 1ns/1ps

module camera_rx_tb;

    import csi2_pkg::*;
    import image_pkg::*;

    logic                  mipi_byte_clock;
    logic                  mipi_byte_reset_n;
    logic [7:0]            byte_data;
    logic                  byte_valid;
    logic [PIXEL_BITS-1:0] pixel;
    logic                  pixel_valid;
    logic                  frame_active;
    logic [METER_BITS-1:0] brightness;
    logic                  brightness_valid;

    logic [7:0]            trace_bytes [$];
    bit                    packet_first [$];    // Set on the data identifier byte
    logic [PIXEL_BITS-1:0] expect_pixels [$];
    logic [METER_BITS-1:0] expect_bright [$];
    int                    pixels_before [$];   // Pixels due before each brightness

    logic [31:0]           lfsr;
    logic                  active_expect;
    int                    error_count;
    int                    frame_errors;
    int                    active_errors;
    int                    pixels_seen;
    int                    frame_pixels;
    int                    bright_seen;

    tb_clock clock0 (
        .mipi_byte_clock_o   (mipi_byte_clock),
        .mipi_byte_reset_n_o (mipi_byte_reset_n)
    );

    camera_rx dut0 (
        .mipi_byte_clock    (mipi_byte_clock),
        .mipi_byte_reset_n  (mipi_byte_reset_n),
        .byte_i             (byte_data),
        .byte_valid_i       (byte_valid),
        .pixel_o            (pixel),
        .pixel_valid_o      (pixel_valid),
        .frame_active_o     (frame_active),
        .brightness_o       (brightness),
        .brightness_valid_o (brightness_valid)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic random_gap(output int gap);
        lfsr = lfsr_next(lfsr);
        gap  = int'(lfsr[0]);
        lfsr = lfsr_next(lfsr);
        gap  = gap * 2 + int'(lfsr[0]);   // 0 to 3 idle cycles
    endtask

    task automatic load_trace;
        int               fd;
        int               status;
        logic [63:0]      token;
        logic [8*128-1:0] rest;
        logic [15:0]      value;
        logic [7:0]       tag;
        bit               new_packet;
        tag        = 8'h00;
        new_packet = 1'b0;
        fd = $fopen("camera_trace.txt", "r");
        assert (fd != 0) else begin
            $display("Cannot open camera_trace.txt");
            error_count++;
        end
        while (fd != 0 && $fscanf(fd, "%s", token) == 1) begin
            if (token == "#") begin
                status = $fgets(rest, fd);   // Rest of a comment line
            end else if (token == "B" || token == "P" || token == "M") begin
                tag        = token[7:0];
                new_packet = (token == "B");
            end else begin
                status = $sscanf(token, "%h", value);
                case (tag)
                    "B": begin
                        trace_bytes.push_back(value[7:0]);
                        packet_first.push_back(new_packet);
                        new_packet = 1'b0;
                    end
                    "P": expect_pixels.push_back(value[PIXEL_BITS-1:0]);
                    "M": begin
                        expect_bright.push_back(value[METER_BITS-1:0]);
                        pixels_before.push_back(expect_pixels.size());
                    end
                    default: begin
                        $display("Trace holds a value before its first tag");
                        error_count++;
                    end
                endcase
            end
        end
        if (fd != 0) $fclose(fd);
        $display("Trace: %0d bytes, %0d pixels, %0d frames",
                 trace_bytes.size(), expect_pixels.size(), expect_bright.size());
    endtask

    task automatic wait_for_reset;
        int cycles;
        cycles = 0;
        while (!mipi_byte_reset_n && cycles < 20) begin
            @(posedge mipi_byte_clock);
            cycles++;
        end
        assert (mipi_byte_reset_n) else begin
            $display("Reset was still asserted after %0d cycles", cycles);
            error_count++;
        end
        @(negedge mipi_byte_clock);
    endtask

    task automatic check_reset_state;
        int errors_before;
        errors_before = error_count;
        assert (!pixel_valid && !brightness_valid && !frame_active && brightness == '0) else begin
            $display("Fail %0t: after reset pixel_valid %b, brightness_valid %b, frame_active %b",
                     $time, pixel_valid, brightness_valid, frame_active);
            error_count++;
        end
        $display("Reset state: %s", error_count == errors_before ? "pass" : "fail");
    endtask

    task automatic drive_trace;
        int         gap;
        logic [7:0] data_id;
        data_id = 8'h00;
        @(posedge mipi_byte_clock);
        for (int i = 0; i < trace_bytes.size(); i++) begin
            random_gap(gap);
            repeat (gap) begin
                byte_valid <= 1'b0;
                @(posedge mipi_byte_clock);
            end
            if (packet_first[i]) data_id = trace_bytes[i];
            byte_data  <= trace_bytes[i];
            byte_valid <= 1'b1;
            @(posedge mipi_byte_clock);
            // Byte taken on this edge, a finished FS or FE packet moves the frame state
            if (i == trace_bytes.size() - 1 || packet_first[i + 1]) begin
                if (data_id[5:0] == DT_FRAME_START) active_expect = 1'b1;
                else if (data_id[5:0] == DT_FRAME_END) active_expect = 1'b0;
            end
        end
        byte_valid <= 1'b0;
    endtask

    task automatic check_pixel;
        logic [PIXEL_BITS-1:0] expected;
        assert (expect_pixels.size() > 0) else begin
            $display("Pixel %h at %0t arrived after all expected pixels", pixel, $time);
            frame_errors++;
            error_count++;
        end
        if (expect_pixels.size() > 0) begin
            expected = expect_pixels.pop_front();
            assert (pixel == expected) else begin
                $display("Fail %0t: pixel %0d is %h, expected %h",
                         $time, pixels_seen, pixel, expected);
                frame_errors++;
                error_count++;
            end
        end
        pixels_seen++;
        frame_pixels++;
    endtask

    task automatic check_brightness;
        int frame;
        frame = bright_seen + 1;
        assert (bright_seen < expect_bright.size()) else begin
            $display("Brightness %0d at %0t came with no frame left in the trace", brightness, $time);
            frame_errors++;
            error_count++;
        end
        if (bright_seen < expect_bright.size()) begin
            assert (pixels_seen == pixels_before[bright_seen]) else begin
                $display("Brightness of frame %0d came after %0d pixels instead of %0d",
                         frame, pixels_seen, pixels_before[bright_seen]);
                frame_errors++;
                error_count++;
            end
            assert (brightness == expect_bright[bright_seen]) else begin
                $display("Fail %0t: brightness of frame %0d is %0d, expected %0d",
                         $time, frame, brightness, expect_bright[bright_seen]);
                frame_errors++;
                error_count++;
            end
        end
        $display("Frame %0d: %0d pixels, brightness %0d, %s",
                 frame, frame_pixels, brightness, frame_errors == 0 ? "pass" : "fail");
        bright_seen++;
        frame_pixels = 0;
        frame_errors = 0;
    endtask

    task automatic wait_for_drain;
        int cycles;
        cycles = 0;
        while ((expect_pixels.size() != 0 || bright_seen < expect_bright.size())
               && cycles < 2000) begin
            @(posedge mipi_byte_clock);
            cycles++;
        end
        assert (expect_pixels.size() == 0 && bright_seen >= expect_bright.size()) else begin
            $display("Timed out with %0d pixels and %0d brightness values still missing",
                     expect_pixels.size(), expect_bright.size() - bright_seen);
            error_count++;
        end
        repeat (20) @(posedge mipi_byte_clock);   // Catch stray outputs
    endtask

    // Outputs are registered, the falling edge sees them settled
    always @(negedge mipi_byte_clock) begin
        if (mipi_byte_reset_n) begin
            if (pixel_valid) check_pixel();
            if (brightness_valid) check_brightness();
            assert (frame_active == active_expect) else begin
                $display("Fail %0t: frame_active_o is %b, expected %b",
                         $time, frame_active, active_expect);
                active_errors++;
                error_count++;
            end
        end
    end

    initial begin
        byte_data     = 8'h00;
        byte_valid    = 1'b0;
        lfsr          = 32'h3ae6;
        active_expect = 1'b0;
        error_count   = 0;
        frame_errors  = 0;
        active_errors = 0;
        pixels_seen   = 0;
        frame_pixels  = 0;
        bright_seen   = 0;

        load_trace();
        wait_for_reset();
        check_reset_state();
        drive_trace();
        wait_for_drain();

        $display("Frame active tracking: %s", active_errors == 0 ? "pass" : "fail");
        $display("%0d pixels and %0d brightness values checked, %0d errors",
                 pixels_seen, bright_seen, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: camera_trace.txt
# Tag then hex values. B is one whole packet of input bytes, header first
# P lists expected cropped pixels in order, M the brightness at that frame's end
# Frame one with FS, line 0, embedded data, lines 1 to 3, FE
B 00 01 00 00
B 2B 19 00 00 00 01 02 03 55 04 05 06 07 55 08 09 0A 0B 55 0C 0D 0E 0F 55 10 11 12 13 55
B 12 06 00 00 AA BB CC DD EE FF
B 2B 19 00 00 20 21 22 23 55 24 25 26 27 55 28 29 2A 2B 55 2C 2D 2E 2F 55 30 31 32 33 55
B 2B 19 00 00 40 41 42 43 55 44 45 46 47 55 48 49 4A 4B 55 4C 4D 4E 4F 55 50 51 52 53 55
B 2B 19 00 00 60 61 62 63 55 64 65 66 67 55 68 69 6A 6B 55 6C 6D 6E 6F 55 70 71 72 73 55
B 01 01 00 00
# Line 1 then line 2, columns 2 to 17
P 089 08D 091 095 099 09D 0A1 0A5 0A9 0AD 0B1 0B5 0B9 0BD 0C1 0C5
P 109 10D 111 115 119 11D 121 125 129 12D 131 135 139 13D 141 145
# Sum 7392 shifted right by 7
M 39
# Frame two with new values and mixed low bits
B 00 02 00 00
B 2B 19 00 00 80 81 82 83 E4 84 85 86 87 E4 88 89 8A 8B E4 8C 8D 8E 8F E4 90 91 92 93 E4
B 2B 19 00 00 A0 A1 A2 A3 E4 A4 A5 A6 A7 E4 A8 A9 AA AB E4 AC AD AE AF E4 B0 B1 B2 B3 E4
B 2B 19 00 00 C0 C1 C2 C3 E4 C4 C5 C6 C7 E4 C8 C9 CA CB E4 CC CD CE CF E4 D0 D1 D2 D3 E4
B 2B 19 00 00 E0 E1 E2 E3 E4 E4 E5 E6 E7 E4 E8 E9 EA EB E4 EC ED EE EF E4 F0 F1 F2 F3 E4
B 01 02 00 00
P 28A 28F 290 295 29A 29F 2A0 2A5 2AA 2AF 2B0 2B5 2BA 2BF 2C0 2C5
P 30A 30F 310 315 31A 31F 320 325 32A 32F 330 335 33A 33F 340 345
# Sum 23792 shifted right by 7
M B9

// File: project.f
csi2_pkg.sv
image_pkg.sv
csi2_packet_parser.sv
raw10_unpacker.sv
crop.sv
metering.sv
camera_rx.sv
tb_clock.sv
camera_rx_tb.sv

// File: Makefile
LOG = sim.log

all: run

run:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module camera_rx_tb -Mdir obj_dir
	./obj_dir/Vcamera_rx_tb | tee $(LOG)
	grep -q "No errors" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f project.f --top-module camera_rx

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean
